// File: hw/binCounterBank.sv
`timescale 1ns/10ps

module binCounterBank (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         accept,
    input  logic [sifhPkg::PIX_BITS-1:0] pixelIdx,
    input  sifhPkg::tsWordT              word,
    input  logic                         scanEn,
    input  logic [sifhPkg::PIX_BITS-1:0] scanPixel,
    input  logic [sifhPkg::BIN_BITS-1:0] scanBin,
    output logic [sifhPkg::CNT_BITS-1:0] scanCount
);

    // one histogram per pixel
    logic [sifhPkg::CNT_BITS-1:0] binCnt [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM];

    // increment path
    logic                         hitValid;
    logic [sifhPkg::BIN_BITS-1:0] hitBin;
    logic [sifhPkg::CNT_BITS-1:0] curCnt;
    logic                         atMax;

    // coarse bin straight from the union
    assign hitBin = word.fields.bin;

    // no-detection words still consume a slot, just not a count
    assign hitValid = accept && (word.raw != sifhPkg::NO_HIT);

    // counter being bumped this cycle
    assign curCnt = binCnt[pixelIdx][hitBin];
    assign atMax = (curCnt == sifhPkg::CNT_MAX);

    // scan read port, combinational
    assign scanCount = binCnt[scanPixel][scanBin];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
                    binCnt[p][b] <= '0;
                end
            end
        end else begin
            // accumulate
            // saturate, a full counter stays full
            if (hitValid && !atMax) begin
                binCnt[pixelIdx][hitBin] <= curCnt + 1'b1;
            end

            // read-and-clear while scanning
            // bins are empty again by the time busy drops
            // accept is low during the scan, so no clash with the bump
            if (scanEn) begin
                binCnt[scanPixel][scanBin] <= '0;
            end
        end
    end

endmodule

// File: hw/hisBuilderFSM.sv
`timescale 1ns/10ps

module hisBuilderFSM (
    input  logic                clk,
    input  logic                rstN,
    input  logic                wrEn,
    input  sifhPkg::tsWordT     data,
    output logic [sifhPkg::Np-1:0] peakResult [sifhPkg::PIXEL_NUM-1:0],
    output logic                peakValid,
    output logic                busy
);

    // sequencer -> bank / finder
    logic                         accept;
    logic [sifhPkg::PIX_BITS-1:0] pixelIdx;
    logic                         frameEnd;

    // finder -> sequencer
    logic                         scanDone;

    // finder <-> bank scan port
    logic                         scanEn;
    logic [sifhPkg::PIX_BITS-1:0] scanPixel;
    logic [sifhPkg::BIN_BITS-1:0] scanBin;
    logic [sifhPkg::CNT_BITS-1:0] scanCount;

    // pixel order, frame boundary, busy window
    pixelSequencer pixelSequencer_i (
        .clk      (clk),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .scanDone (scanDone),
        .accept   (accept),
        .pixelIdx (pixelIdx),
        .frameEnd (frameEnd),
        .busy     (busy)
    );

    // histogram storage
    // raw word goes straight in, bank decodes the bin itself
    binCounterBank binCounterBank_i (
        .clk       (clk),
        .rstN      (rstN),
        .accept    (accept),
        .pixelIdx  (pixelIdx),
        .word      (data),
        .scanEn    (scanEn),
        .scanPixel (scanPixel),
        .scanBin   (scanBin),
        .scanCount (scanCount)
    );

    // argmax per pixel once a frame is complete
    peakFinder peakFinder_i (
        .clk        (clk),
        .rstN       (rstN),
        .frameEnd   (frameEnd),
        .scanCount  (scanCount),
        .scanEn     (scanEn),
        .scanPixel  (scanPixel),
        .scanBin    (scanBin),
        .scanDone   (scanDone),
        .peakResult (peakResult),
        .peakValid  (peakValid)
    );

endmodule

// File: hw/peakFinder.sv
`timescale 1ns/10ps

module peakFinder (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         frameEnd,
    input  logic [sifhPkg::CNT_BITS-1:0] scanCount,
    output logic                         scanEn,
    output logic [sifhPkg::PIX_BITS-1:0] scanPixel,
    output logic [sifhPkg::BIN_BITS-1:0] scanBin,
    output logic                         scanDone,
    output logic [sifhPkg::Np-1:0]       peakResult [sifhPkg::PIXEL_NUM-1:0],
    output logic                         peakValid
);

    logic                         state;

    // running best for the current pixel
    logic [sifhPkg::CNT_BITS-1:0] bestCnt;
    logic [sifhPkg::BIN_BITS-1:0] bestBin;

    // best including the bin on the port right now
    logic [sifhPkg::CNT_BITS-1:0] candCnt;
    logic [sifhPkg::BIN_BITS-1:0] candBin;

    logic                         lastBin;
    logic                         lastPixel;

    // timestamp rebuilt from the winning bin
    sifhPkg::tsWordT              pixResult;

    // results of finished pixels, published all at once
    logic [sifhPkg::Np-1:0]       stage [sifhPkg::PIXEL_NUM];

    assign scanEn = (state == sifhPkg::ST_SCAN);
    assign lastBin = (scanBin == sifhPkg::LAST_BIN);
    assign lastPixel = (scanPixel == sifhPkg::LAST_PIXEL);

    // last bin of last pixel is on the port
    assign scanDone = scanEn && lastBin && lastPixel;

    // bin 0 restarts the search
    // strictly greater only, so a tie keeps the lower bin
    always_comb begin
        if (scanBin == '0 || scanCount > bestCnt) begin
            candCnt = scanCount;
            candBin = scanBin;
        end else begin
            candCnt = bestCnt;
            candBin = bestBin;
        end
    end

    // bin centre, or no-hit for an empty histogram
    always_comb begin
        pixResult.fields.bin = candBin;
        pixResult.fields.fine = sifhPkg::FINE_CENTER;
        if (candCnt == '0) begin
            pixResult.raw = sifhPkg::NO_HIT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sifhPkg::ST_IDLE;
            scanPixel <= '0;
            scanBin <= '0;
            bestCnt <= '0;
            bestBin <= '0;
            peakValid <= 1'b0;
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                peakResult[p] <= sifhPkg::NO_HIT;
            end
        end else begin
            // one-cycle pulse
            peakValid <= 1'b0;
            case (state)
                sifhPkg::ST_IDLE: begin
                    if (frameEnd) begin
                        state <= sifhPkg::ST_SCAN;
                        scanPixel <= '0;
                        scanBin <= '0;
                    end
                end
                sifhPkg::ST_SCAN: begin
                    // one bin per cycle, bin index wraps on its own
                    bestCnt <= candCnt;
                    bestBin <= candBin;
                    scanBin <= scanBin + 1'b1;
                    if (lastBin) begin
                        stage[scanPixel] <= pixResult.raw;
                        if (lastPixel) begin
                            scanPixel <= '0;
                            state <= sifhPkg::ST_IDLE;
                            peakValid <= 1'b1;
                            // current pixel bypasses the stage
                            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                                if (p == int'(scanPixel)) begin
                                    peakResult[p] <= pixResult.raw;
                                end else begin
                                    peakResult[p] <= stage[p];
                                end
                            end
                        end else begin
                            scanPixel <= scanPixel + 1'b1;
                        end
                    end
                end
                default: state <= sifhPkg::ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/pixelSequencer.sv
`timescale 1ns/10ps

module pixelSequencer (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wrEn,
    input  logic                         scanDone,
    output logic                         accept,
    output logic [sifhPkg::PIX_BITS-1:0] pixelIdx,
    output logic                         frameEnd,
    output logic                         busy
);

    // acquisition round within the frame
    logic [sifhPkg::ACQ_BITS-1:0] acqIdx;
    logic                         lastPixel;
    logic                         lastAcq;

    // words during the scan are simply dropped
    assign accept = wrEn && !busy;

    assign lastPixel = (pixelIdx == sifhPkg::LAST_PIXEL);
    assign lastAcq = (acqIdx == sifhPkg::LAST_ACQ);

    // last pixel of last acquisition closes the frame
    assign frameEnd = accept && lastPixel && lastAcq;

    // position in the frame, moves only on accepted words
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixelIdx <= '0;
            acqIdx <= '0;
        end else if (accept) begin
            if (lastPixel) begin
                pixelIdx <= '0;
                // wrap to acquisition 0 at frame end
                if (lastAcq) begin
                    acqIdx <= '0;
                end else begin
                    acqIdx <= acqIdx + 1'b1;
                end
            end else begin
                pixelIdx <= pixelIdx + 1'b1;
            end
        end
    end

    // busy window covers the whole peak scan
    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (frameEnd) begin
            busy <= 1'b1;
        end else if (scanDone) begin
            // drops together with peakValid
            busy <= 1'b0;
        end
    end

endmodule

// File: hw/sifhPkg.sv
package sifhPkg;

    // timestamp word
    localparam int Np = 10;

    // pixel group and frame shape
    localparam int PIXEL_NUM = 3;
    localparam int ACQ_NUM = 4;
    localparam int FRAME_WORDS = PIXEL_NUM * ACQ_NUM;

    // coarse/fine split of a timestamp
    localparam int BIN_BITS = 4;
    localparam int BIN_NUM = 1 << BIN_BITS;
    localparam int FINE_BITS = Np - BIN_BITS;

    // histogram counters saturate at all ones
    localparam int CNT_BITS = 8;
    localparam logic [CNT_BITS-1:0] CNT_MAX = {CNT_BITS{1'b1}};

    // index widths and last positions
    localparam int PIX_BITS = $clog2(PIXEL_NUM);
    localparam int ACQ_BITS = $clog2(ACQ_NUM);
    localparam logic [PIX_BITS-1:0] LAST_PIXEL = PIX_BITS'(PIXEL_NUM - 1);
    localparam logic [ACQ_BITS-1:0] LAST_ACQ = ACQ_BITS'(ACQ_NUM - 1);
    localparam logic [BIN_BITS-1:0] LAST_BIN = BIN_BITS'(BIN_NUM - 1);

    // all ones = no detection in this acquisition
    localparam logic [Np-1:0] NO_HIT = {Np{1'b1}};

    // middle of a bin, used when rebuilding a timestamp from a bin index
    localparam logic [FINE_BITS-1:0] FINE_CENTER = FINE_BITS'(1 << (FINE_BITS - 1));

    // peak finder states
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_SCAN = 1'b1;

    // one timestamp word, seen either raw or as bin + fine offset
    typedef union packed {
        logic [Np-1:0] raw;
        struct packed {
            logic [BIN_BITS-1:0] bin;
            logic [FINE_BITS-1:0] fine;
        } fields;
    } tsWordT;

endpackage

// File: run.sh
#!/bin/sh
# compile and run the histogram builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hisBuilderTb -f sifh.f -o hisBuilderSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

# assertion errors must not stop the run before the summary
./obj_dir/hisBuilderSim +verilator+error+limit+1000 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

// File: sifh.f
hw/sifhPkg.sv
hw/pixelSequencer.sv
hw/binCounterBank.sv
hw/peakFinder.sv
hw/hisBuilderFSM.sv
test/hisBuilder_chk.sv
test/hisBuilderTb.sv

// File: test/hisBuilderTb.sv
`timescale 1ns/10ps

module hisBuilderTb;

    // one accepting edge, then one edge per scanned bin
    localparam int LATENCY = 1 + sifhPkg::PIXEL_NUM * sifhPkg::BIN_NUM;
    localparam int WAIT_LIMIT = 200;
    localparam int IDLE_LIMIT = 1000;
    localparam int RANDOM_FRAMES = 40;
    localparam int FINE_SPAN = 1 << sifhPkg::FINE_BITS;
    localparam logic [sifhPkg::Np-1:0] ALL_ONES = {sifhPkg::Np{1'b1}};

    logic                   clk;
    logic                   rstN;
    logic                   wrEn;
    sifhPkg::tsWordT        data;
    logic [sifhPkg::Np-1:0] peakResult [sifhPkg::PIXEL_NUM-1:0];
    logic                   peakValid;
    logic                   busy;

    int errCnt = 0;
    int timeoutCnt = 0;
    int checkCnt = 0;
    int cycleCnt = 0;
    int lastDriveCycle = 0;
    bit stimDone = 1'b0;
    bit compareDone = 1'b0;

    // current frame, pixel order within each acquisition
    logic [sifhPkg::Np-1:0] frameBuf [sifhPkg::FRAME_WORDS];
    // expected peaks, PIXEL_NUM per frame
    logic [sifhPkg::Np-1:0] expQ [$];
    // cycle on which each frame's last word went out
    int launchQ [$];

    hisBuilderFSM hisBuilderFSM_i (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .data       (data),
        .peakResult (peakResult),
        .peakValid  (peakValid),
        .busy       (busy)
    );

    bind hisBuilderFSM hisBuilderChk hisBuilderChk_i (
        .clk       (clk),
        .rstN      (rstN),
        .frameEnd  (frameEnd),
        .busy      (busy),
        .peakValid (peakValid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // expected peak of one pixel from the stored frame
    function automatic logic [sifhPkg::Np-1:0] expectedPeak(input int pix);
        int cnt [sifhPkg::BIN_NUM];
        int best;
        int bestBin;
        int binIdx;
        logic [sifhPkg::Np-1:0] w;
        for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
            cnt[b] = 0;
        end
        for (int a = 0; a < sifhPkg::ACQ_NUM; a++) begin
            w = frameBuf[a * sifhPkg::PIXEL_NUM + pix];
            // all-ones word is a missed detection
            if (w != ALL_ONES) begin
                binIdx = int'(w) / FINE_SPAN;
                if (cnt[binIdx] < (1 << sifhPkg::CNT_BITS) - 1) begin
                    cnt[binIdx]++;
                end
            end
        end
        best = 0;
        bestBin = 0;
        // strictly greater, so ties stay on the lower bin
        for (int b = 0; b < sifhPkg::BIN_NUM; b++) begin
            if (cnt[b] > best) begin
                best = cnt[b];
                bestBin = b;
            end
        end
        if (best == 0) begin
            return ALL_ONES;
        end
        return sifhPkg::Np'(bestBin * FINE_SPAN + FINE_SPAN / 2);
    endfunction

    function automatic logic [sifhPkg::Np-1:0] makeWord(input int binIdx, input int fine);
        return sifhPkg::Np'(binIdx * FINE_SPAN + fine);
    endfunction

    task automatic setWord(input int acq, input int pix, input logic [sifhPkg::Np-1:0] w);
        frameBuf[acq * sifhPkg::PIXEL_NUM + pix] = w;
    endtask

    // idle until the scan window closes
    task automatic waitNotBusy();
        int waited;
        waited = 0;
        while (busy && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            $display("timeout at %0t: busy stayed high for %0d cycles", $time, WAIT_LIMIT);
            timeoutCnt++;
        end
    endtask

    task automatic driveWord(input logic [sifhPkg::Np-1:0] w);
        waitNotBusy();
        lastDriveCycle = cycleCnt;
        wrEn = 1'b1;
        data.raw = w;
        @(posedge clk);
        #1;
        wrEn = 1'b0;
    endtask

    // whole frame, with an occasional idle cycle between words
    task automatic sendFrame();
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            expQ.push_back(expectedPeak(p));
        end
        for (int i = 0; i < sifhPkg::FRAME_WORDS; i++) begin
            if ($urandom_range(3) == 0) begin
                @(posedge clk);
                #1;
            end
            driveWord(frameBuf[i]);
        end
        launchQ.push_back(lastDriveCycle);
    endtask

    // junk while the scan runs, none of it may land
    task automatic driveDuringBusy();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            wrEn = 1'b1;
            data.raw = sifhPkg::Np'($urandom);
            @(posedge clk);
            #1;
            n++;
        end
        wrEn = 1'b0;
        if (busy) begin
            $display("timeout at %0t: busy stayed high while driving junk", $time);
            timeoutCnt++;
        end
    endtask

    task automatic fillClustered();
        int centre;
        int binIdx;
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            centre = $urandom_range(sifhPkg::BIN_NUM - 1);
            for (int a = 0; a < sifhPkg::ACQ_NUM; a++) begin
                binIdx = centre;
                // a stray neighbour now and then
                if ($urandom_range(3) == 0) begin
                    binIdx = (centre + 1) % sifhPkg::BIN_NUM;
                end
                setWord(a, p, makeWord(binIdx, $urandom_range(FINE_SPAN - 2)));
            end
        end
    endtask

    // pixel 1 sees nothing, pixel 2 half misses at the top bin
    task automatic fillEmptyPixel();
        for (int a = 0; a < sifhPkg::ACQ_NUM; a++) begin
            setWord(a, 0, makeWord(4, 3 * a));
            setWord(a, 1, ALL_ONES);
            setWord(a, 2, (a % 2 == 0) ? ALL_ONES : makeWord(15, 17 * a));
        end
    endtask

    // equal counts in several bins per pixel
    task automatic fillTie();
        setWord(0, 0, makeWord(9, 1));
        setWord(1, 0, makeWord(3, 2));
        setWord(2, 0, makeWord(9, 3));
        setWord(3, 0, makeWord(3, 4));
        setWord(0, 1, makeWord(5, 10));
        setWord(1, 1, makeWord(12, 11));
        setWord(2, 1, makeWord(12, 12));
        setWord(3, 1, makeWord(5, 13));
        setWord(0, 2, makeWord(14, 20));
        setWord(1, 2, makeWord(2, 21));
        setWord(2, 2, makeWord(7, 22));
        setWord(3, 2, makeWord(11, 23));
    endtask

    task automatic fillRandom();
        for (int i = 0; i < sifhPkg::FRAME_WORDS; i++) begin
            if ($urandom_range(4) == 0) begin
                frameBuf[i] = ALL_ONES;
            end else begin
                frameBuf[i] = makeWord($urandom_range(sifhPkg::BIN_NUM - 1),
                                       $urandom_range(FINE_SPAN - 1));
            end
        end
    endtask

    task automatic checkResetState();
        checkCnt++;
        if (busy !== 1'b0 || peakValid !== 1'b0) begin
            $display("FAIL %0t: after reset busy=%b peakValid=%b", $time, busy, peakValid);
            errCnt++;
        end
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            if (peakResult[p] !== ALL_ONES) begin
                $display("FAIL %0t: after reset pixel %0d result 0x%0h", $time, p, peakResult[p]);
                errCnt++;
            end
        end
    endtask

    task automatic checkPeaks(input int latency);
        logic [sifhPkg::Np-1:0] want;
        checkCnt++;
        if (latency != LATENCY) begin
            $display("FAIL %0t: peakValid %0d cycles after last word, expected %0d",
                     $time, latency, LATENCY);
            errCnt++;
        end
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            want = expQ.pop_front();
            checkCnt++;
            if (peakResult[p] !== want) begin
                $display("FAIL %0t: pixel %0d peak 0x%0h, expected 0x%0h",
                         $time, p, peakResult[p], want);
                errCnt++;
            end
        end
    endtask

    // compare at the falling edge, away from the drive point
    initial begin : compareResults
        int idle;
        idle = 0;
        while (!(stimDone && launchQ.size() == 0) && idle < IDLE_LIMIT) begin
            @(negedge clk);
            idle++;
            if (peakValid) begin
                idle = 0;
                if (launchQ.size() == 0) begin
                    $display("error at %0t: peakValid with no frame outstanding", $time);
                    errCnt++;
                end else begin
                    checkPeaks(cycleCnt - launchQ.pop_front());
                end
            end else if (launchQ.size() != 0 && cycleCnt - launchQ[0] > WAIT_LIMIT) begin
                $display("timeout at %0t: no peakValid within %0d cycles of frame end",
                         $time, WAIT_LIMIT);
                timeoutCnt++;
                void'(launchQ.pop_front());
                repeat (sifhPkg::PIXEL_NUM) void'(expQ.pop_front());
            end
        end
        if (idle >= IDLE_LIMIT) begin
            $display("timeout at %0t: compare process idle for %0d cycles", $time, IDLE_LIMIT);
            timeoutCnt++;
        end
        compareDone = 1'b1;
    end

    initial begin : runTest
        int waited;
        int assertFails;
        void'($urandom(32'hdfa7d365));
        rstN = 1'b0;
        wrEn = 1'b0;
        data.raw = '0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkResetState();

        fillClustered();
        sendFrame();
        fillEmptyPixel();
        sendFrame();
        driveDuringBusy();
        fillTie();
        sendFrame();
        driveDuringBusy();
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            fillRandom();
            sendFrame();
            if (f % 3 == 0) begin
                driveDuringBusy();
            end
        end
        stimDone = 1'b1;

        waited = 0;
        while (!compareDone && waited < WAIT_LIMIT * 4) begin
            @(posedge clk);
            waited++;
        end
        if (!compareDone) begin
            $display("timeout: compare process did not finish");
            timeoutCnt++;
        end

        assertFails = hisBuilderFSM_i.hisBuilderChk_i.assertFails;
        $display("summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checkCnt, errCnt, timeoutCnt, assertFails);
        if (errCnt == 0 && timeoutCnt == 0 && assertFails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: test/hisBuilder_chk.sv
`timescale 1ns/10ps

module hisBuilderChk (
    input logic clk,
    input logic rstN,
    input logic frameEnd,
    input logic busy,
    input logic peakValid
);

    // failed assertion count
    int assertFails = 0;

    // result strobe lasts one cycle
    validPulse: assert property (@(posedge clk) disable iff (!rstN)
        peakValid |=> !peakValid)
        else begin
            $error("peakValid stayed high for more than one cycle");
            assertFails++;
        end

    // results appear as the scan window closes
    validOnBusyFall: assert property (@(posedge clk) disable iff (!rstN)
        peakValid |-> $fell(busy))
        else begin
            $error("peakValid without busy falling");
            assertFails++;
        end

    busyFallOnValid: assert property (@(posedge clk) disable iff (!rstN)
        $fell(busy) |-> peakValid)
        else begin
            $error("busy fell without peakValid");
            assertFails++;
        end

    // scan window opens right after the last word of a frame
    busyAfterFrame: assert property (@(posedge clk) disable iff (!rstN)
        frameEnd |=> $rose(busy))
        else begin
            $error("busy did not rise one cycle after frame end");
            assertFails++;
        end

endmodule
